//--- logic/icache_pkg.sv
package icache_pkg;

	localparam int ADDR_W         = 64;
	localparam int WORD_W         = 64;
	localparam int OFFSET_W       = 5;  // 32-byte line
	localparam int WORDS_PER_LINE = 4;
	localparam int BEAT_W         = 2;
	localparam int BEAT_LSB       = 3;  // word select is addr[4:3]

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [BEAT_W-1:0] beat_t;

	// stage 1 -> stage 2
	typedef struct packed {
		logic  valid;
		addr_t addr;
	} lookup_s;

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		REQUEST = 2'd1,
		FILL    = 2'd2,
		REPLAY  = 2'd3
	} refill_state_e;

endpackage

//--- logic/icache_tag_store.sv
`timescale 1ns/10ps

module icache_tag_store import icache_pkg::*; #(
	parameter int INDEX_W = 6
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [INDEX_W-1:0]               rd_index,
	output logic [ADDR_W-OFFSET_W-INDEX_W-1:0] rd_tag0,
	output logic [ADDR_W-OFFSET_W-INDEX_W-1:0] rd_tag1,
	output logic [1:0]                       rd_valid,
	output logic                             rd_lru,
	input  logic                             wr_en,
	input  logic [INDEX_W-1:0]               wr_index,
	input  logic                             wr_way,
	input  logic [ADDR_W-OFFSET_W-INDEX_W-1:0] wr_tag,
	input  logic                             touch_en,
	input  logic [INDEX_W-1:0]               touch_index,
	input  logic                             touch_way
);

	localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;
	localparam int SETS  = 1 << INDEX_W;

	logic [TAG_W-1:0] tag0 [SETS];
	logic [TAG_W-1:0] tag1 [SETS];
	logic [1:0]       valid [SETS];
	logic [SETS-1:0]  lru;  // points at the least recently used way

	always_ff @(posedge clk) begin
		if (wr_en && !wr_way)
			tag0[wr_index] <= wr_tag;
		if (wr_en && wr_way)
			tag1[wr_index] <= wr_tag;
		rd_tag0 <= tag0[rd_index];
		rd_tag1 <= tag1[rd_index];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < SETS; i++)
				valid[i] <= 2'b00;
			lru      <= '0;
			rd_valid <= 2'b00;
			rd_lru   <= 1'b0;
		end else begin
			if (wr_en)
				valid[wr_index][wr_way] <= 1'b1;
			if (touch_en)
				lru[touch_index] <= ~touch_way;
			rd_valid <= valid[rd_index];
			rd_lru   <= lru[rd_index];
		end
	end

endmodule

//--- logic/icache_data_store.sv
`timescale 1ns/10ps

module icache_data_store import icache_pkg::*; #(
	parameter int INDEX_W = 6
) (
	input  logic               clk,
	input  logic [INDEX_W-1:0] rd_index,
	input  beat_t              rd_beat,
	output word_t              rd_word0,
	output word_t              rd_word1,
	input  logic               wr_en,
	input  logic [INDEX_W-1:0] wr_index,
	input  logic               wr_way,
	input  beat_t              wr_beat,
	input  word_t              wr_data
);

	localparam int DEPTH = (1 << INDEX_W) * WORDS_PER_LINE;

	// word address is {index, beat}
	word_t way0 [DEPTH];
	word_t way1 [DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en && !wr_way)
			way0[{wr_index, wr_beat}] <= wr_data;
		if (wr_en && wr_way)
			way1[{wr_index, wr_beat}] <= wr_data;
		rd_word0 <= way0[{rd_index, rd_beat}];
		rd_word1 <= way1[{rd_index, rd_beat}];
	end

endmodule

//--- logic/icache_lookup_stage.sv
`timescale 1ns/10ps

module icache_lookup_stage import icache_pkg::*; #(
	parameter int INDEX_W = 6
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cpu_req_valid,
	input  addr_t              cpu_req_addr,
	input  logic               freeze,
	input  logic               replay,
	input  addr_t              miss_addr,
	output lookup_s            lookup,
	output logic [INDEX_W-1:0] rd_index,
	output beat_t              rd_beat
);

	lookup_s req;    // accepted request, waits here for the stores
	addr_t   next_addr;

	always_comb begin
		next_addr = replay ? miss_addr : req.addr;
		rd_index  = next_addr[OFFSET_W +: INDEX_W];
		rd_beat   = next_addr[BEAT_LSB +: BEAT_W];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req    <= '0;
			lookup <= '0;
		end else if (replay) begin
			lookup <= '{valid: 1'b1, addr: miss_addr}; // req keeps the held request
		end else if (freeze) begin
			lookup.valid <= 1'b0;
		end else begin
			lookup <= req;
			req    <= '{valid: cpu_req_valid, addr: cpu_req_addr};
		end
	end

endmodule

//--- logic/icache_hit_stage.sv
`timescale 1ns/10ps

module icache_hit_stage import icache_pkg::*; #(
	parameter int INDEX_W = 6
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  lookup_s                            lookup,
	input  logic [ADDR_W-OFFSET_W-INDEX_W-1:0] rd_tag0,
	input  logic [ADDR_W-OFFSET_W-INDEX_W-1:0] rd_tag1,
	input  logic [1:0]                         rd_valid,
	input  logic                               rd_lru,
	input  word_t                              rd_word0,
	input  word_t                              rd_word1,
	input  logic                               freeze,
	output logic                               cpu_ready,
	output word_t                              cpu_data_read,
	output logic                               touch_en,
	output logic [INDEX_W-1:0]                 touch_index,
	output logic                               touch_way,
	output logic                               miss,
	output logic                               victim_way,
	output addr_t                              miss_addr
);

	localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;

	logic [TAG_W-1:0] tag;
	logic             hit0;
	logic             hit1;
	logic             hit;

	always_comb begin
		tag  = lookup.addr[ADDR_W-1 -: TAG_W];
		hit0 = rd_valid[0] && (rd_tag0 == tag);
		hit1 = rd_valid[1] && (rd_tag1 == tag);
		hit  = lookup.valid && (hit0 || hit1);
		miss = lookup.valid && !hit;

		// invalid way first, way 0 before way 1, then lru
		if (!rd_valid[0])
			victim_way = 1'b0;
		else if (!rd_valid[1])
			victim_way = 1'b1;
		else
			victim_way = rd_lru;

		miss_addr   = lookup.addr;
		touch_en    = hit && !freeze;
		touch_index = lookup.addr[OFFSET_W +: INDEX_W];
		touch_way   = hit1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			cpu_ready <= 1'b0;
		else
			cpu_ready <= hit && !freeze;
	end

	always_ff @(posedge clk) begin
		if (hit && !freeze)
			cpu_data_read <= hit1 ? rd_word1 : rd_word0; // held between pulses
	end

endmodule

//--- logic/icache_refill.sv
`timescale 1ns/10ps

module icache_refill import icache_pkg::*; #(
	parameter int INDEX_W = 6
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               miss,
	input  logic                               victim_way,
	input  addr_t                              miss_addr,
	output addr_t                              mem_req_addr,
	output logic                               mem_req_valid,
	input  word_t                              mem_data_read,
	input  logic                               mem_ready,
	output logic                               freeze,
	output logic                               replay,
	output logic                               tag_wr_en,
	output logic [INDEX_W-1:0]                 tag_wr_index,
	output logic                               tag_wr_way,
	output logic [ADDR_W-OFFSET_W-INDEX_W-1:0] tag_wr_tag,
	output logic                               data_wr_en,
	output logic [INDEX_W-1:0]                 data_wr_index,
	output logic                               data_wr_way,
	output beat_t                              data_wr_beat,
	output word_t                              data_wr_data
);

	localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;

	refill_state_e state;
	addr_t         line_addr;
	logic          way;
	beat_t         beat_cnt;
	logic          beat_in;

	assign beat_in = mem_ready && (state == REQUEST || state == FILL);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				IDLE: if (miss) begin
					state    <= REQUEST;
					beat_cnt <= '0;
				end
				REQUEST: if (mem_ready) begin
					state    <= FILL;
					beat_cnt <= beat_cnt + 1'b1;
				end
				FILL: if (mem_ready) begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == beat_t'(WORDS_PER_LINE - 1))
						state <= REPLAY;
				end
				default: state <= IDLE;  // REPLAY
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && miss) begin
			line_addr <= {miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
			way       <= victim_way;
		end
	end

	always_comb begin
		// request goes out in the miss cycle itself, together with busy
		mem_req_valid = (state == IDLE && miss) || state == REQUEST;
		mem_req_addr  = (state == IDLE) ?
			{miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} : line_addr;
		freeze = (state != IDLE) || miss;
		replay = (state == REPLAY);

		data_wr_en    = beat_in;
		data_wr_index = line_addr[OFFSET_W +: INDEX_W];
		data_wr_way   = way;
		data_wr_beat  = beat_cnt;
		data_wr_data  = mem_data_read;

		tag_wr_en    = beat_in && state == FILL && beat_cnt == beat_t'(WORDS_PER_LINE - 1);
		tag_wr_index = line_addr[OFFSET_W +: INDEX_W];
		tag_wr_way   = way;
		tag_wr_tag   = line_addr[ADDR_W-1 -: TAG_W];
	end

endmodule

//--- logic/icache_top.sv
`timescale 1ns/10ps

module icache_top import icache_pkg::*; #(
	parameter int INDEX_W = 6
) (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  cpu_req_valid,
	input  addr_t cpu_req_addr,
	output word_t cpu_data_read,
	output logic  cpu_ready,
	output logic  cpu_busy,
	output addr_t mem_req_addr,
	output logic  mem_req_valid,
	input  word_t mem_data_read,
	input  logic  mem_ready
);

	localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_W;

	lookup_s            lookup;
	logic [INDEX_W-1:0] rd_index;
	beat_t              rd_beat;
	logic [TAG_W-1:0]   rd_tag0, rd_tag1;
	logic [1:0]         rd_valid;
	logic               rd_lru;
	word_t              rd_word0, rd_word1;
	logic               touch_en, touch_way;
	logic [INDEX_W-1:0] touch_index;
	logic               miss, victim_way, freeze, replay;
	addr_t              miss_addr;
	logic               tag_wr_en, tag_wr_way;
	logic [INDEX_W-1:0] tag_wr_index;
	logic [TAG_W-1:0]   tag_wr_tag;
	logic               data_wr_en, data_wr_way;
	logic [INDEX_W-1:0] data_wr_index;
	beat_t              data_wr_beat;
	word_t              data_wr_data;

	assign cpu_busy = freeze;

	icache_lookup_stage #(.INDEX_W(INDEX_W)) lookup0 (.clk, .rst_n, .cpu_req_valid,
		.cpu_req_addr, .freeze, .replay, .miss_addr, .lookup, .rd_index, .rd_beat);

	icache_tag_store #(.INDEX_W(INDEX_W)) tags0 (.clk, .rst_n, .rd_index, .rd_tag0,
		.rd_tag1, .rd_valid, .rd_lru, .wr_en(tag_wr_en), .wr_index(tag_wr_index),
		.wr_way(tag_wr_way), .wr_tag(tag_wr_tag), .touch_en, .touch_index, .touch_way);

	icache_data_store #(.INDEX_W(INDEX_W)) data0 (.clk, .rd_index, .rd_beat, .rd_word0,
		.rd_word1, .wr_en(data_wr_en), .wr_index(data_wr_index), .wr_way(data_wr_way),
		.wr_beat(data_wr_beat), .wr_data(data_wr_data));

	icache_hit_stage #(.INDEX_W(INDEX_W)) hit0 (.clk, .rst_n, .lookup, .rd_tag0, .rd_tag1,
		.rd_valid, .rd_lru, .rd_word0, .rd_word1, .freeze, .cpu_ready, .cpu_data_read,
		.touch_en, .touch_index, .touch_way, .miss, .victim_way, .miss_addr);

	icache_refill #(.INDEX_W(INDEX_W)) refill0 (.clk, .rst_n, .miss, .victim_way,
		.miss_addr, .mem_req_addr, .mem_req_valid, .mem_data_read, .mem_ready, .freeze,
		.replay, .tag_wr_en, .tag_wr_index, .tag_wr_way, .tag_wr_tag, .data_wr_en,
		.data_wr_index, .data_wr_way, .data_wr_beat, .data_wr_data);

endmodule

//--- dv/icache_mem_model.sv
`timescale 1ns/10ps

module icache_mem_model import icache_pkg::*; #(
	parameter word_t PATTERN = '0
) (
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t mem_req_addr,
	input  logic  mem_req_valid,
	output word_t mem_data_read,
	output logic  mem_ready
);

	int    seed;
	int    gap;
	addr_t line;

	initial begin
		seed          = 19;
		mem_ready     = 1'b0;
		mem_data_read = '0;
		forever begin
			@(posedge clk);
			#1;
			if (rst_n && mem_req_valid) begin
				line = mem_req_addr;
				@(posedge clk); // the cache takes no beat in its miss cycle
				#1;
				for (int b = 0; b < WORDS_PER_LINE; b++) begin
					gap = $random(seed) & 3;
					repeat (gap) begin
						@(posedge clk);
						#1;
					end
					mem_ready     = 1'b1;
					mem_data_read = ((line >> 3) + addr_t'(b)) ^ PATTERN; // word addr xor pattern
					@(posedge clk);
					#1;
					mem_ready = 1'b0;
				end
			end
		end
	end

endmodule

//--- dv/icache_checker.sv
`timescale 1ns/10ps

module icache_checker (
	input logic clk,
	input logic rst_n,
	input logic cpu_ready,
	input logic cpu_busy,
	input logic mem_req_valid
);

	int fail_cnt = 0;

	// a pulse is only launched from a cycle with busy low
	ready_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ready |-> !$past(cpu_busy))
		else begin
			$error("cpu_ready raised from a busy cycle");
			fail_cnt++;
		end

	req_rise_busy: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem_req_valid) |-> $rose(cpu_busy))
		else begin
			$error("mem_req_valid rose without cpu_busy rising");
			fail_cnt++;
		end

	req_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req_valid |-> cpu_busy)
		else begin
			$error("mem_req_valid high while cpu_busy low");
			fail_cnt++;
		end

	quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> !cpu_ready && !cpu_busy && !mem_req_valid)
		else begin
			$error("control output high right after reset");
			fail_cnt++;
		end

endmodule

bind icache_top icache_checker chk0 (
	.clk,
	.rst_n,
	.cpu_ready,
	.cpu_busy,
	.mem_req_valid
);

//--- dv/icache_tb.sv
`timescale 1ns/10ps

module icache_tb import icache_pkg::*; ();

	localparam int    INDEX_W  = 6;
	localparam int    SETS     = 1 << INDEX_W;
	localparam word_t PATTERN  = 64'h5a5a_0f0f_c3c3_9696;
	localparam int    NUM_ROWS = 17;
	localparam int    RERUN    = 2;   // rows fetched again after the second reset
	localparam int    LIMIT    = 200; // cycles per wait

	typedef struct packed {
		addr_t addr;
		logic  expect_miss;
		logic  gap; // wait for idle first
	} row_s;

	typedef struct packed {
		int    test;
		addr_t addr;
		logic  miss;      // predicted by the reference cache
		logic  miss_seen;
		logic  delayed;   // stuck behind a refill
		int    issued;
	} fetch_s;

	logic  clk, rst_n, cpu_req_valid, cpu_ready, cpu_busy, mem_req_valid, mem_ready;
	addr_t cpu_req_addr, mem_req_addr;
	word_t cpu_data_read, mem_data_read;

	row_s   rows [NUM_ROWS];
	fetch_s pending [$];
	addr_t  ref_tag [2][SETS];
	logic   ref_valid [2][SETS];
	logic   ref_lru [SETS];
	logic   last_mem_req;
	int     cycle, tests, errors, next_test;

	icache_top #(.INDEX_W(INDEX_W)) dut0 (.*);

	icache_mem_model #(.PATTERN(PATTERN)) mem0 (.clk, .rst_n, .mem_req_addr, .mem_req_valid,
		.mem_data_read, .mem_ready);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic word_t expected_word(addr_t a);
		return (a >> 3) ^ PATTERN;
	endfunction

	function automatic addr_t line_of(addr_t a);
		return (a >> OFFSET_W) << OFFSET_W;
	endfunction

	task automatic load_table();
		rows[0]  = '{64'h0000_1038, 1'b1, 1'b1}; // cold miss mid-line in set 1
		rows[1]  = '{64'h0000_1028, 1'b0, 1'b1};
		rows[2]  = '{64'h0000_1030, 1'b0, 1'b0}; // back to back hits
		rows[3]  = '{64'h0000_1038, 1'b0, 1'b0};
		rows[4]  = '{64'h0000_1020, 1'b0, 1'b0};
		rows[5]  = '{64'h0000_3028, 1'b1, 1'b1}; // second tag, other way
		rows[6]  = '{64'h0000_3020, 1'b0, 1'b1};
		rows[7]  = '{64'h0000_1030, 1'b0, 1'b0};
		rows[8]  = '{64'h0000_5030, 1'b1, 1'b1}; // evicts the 0x3020 line
		rows[9]  = '{64'h0000_1038, 1'b0, 1'b1};
		rows[10] = '{64'h0000_3030, 1'b1, 1'b1};
		rows[11] = '{64'h0000_8048, 1'b1, 1'b1}; // miss with a hit right behind
		rows[12] = '{64'h0000_8040, 1'b0, 1'b0};
		rows[13] = '{64'h0000_1028, 1'b0, 1'b0};
		rows[14] = '{64'h0000_9068, 1'b1, 1'b1}; // miss with a miss right behind
		rows[15] = '{64'h0000_a090, 1'b1, 1'b0};
		rows[16] = '{64'h0000_a098, 1'b0, 1'b1};
	endtask

	task automatic clear_ref();
		for (int s = 0; s < SETS; s++) begin
			ref_valid[0][s] = 1'b0;
			ref_valid[1][s] = 1'b0;
			ref_lru[s]      = 1'b0;
		end
	endtask

	task automatic predict(input addr_t a, output logic miss);
		int    s;
		addr_t t;
		logic  way;
		s    = int'((a >> OFFSET_W) % addr_t'(SETS));
		t    = a >> (OFFSET_W + INDEX_W);
		miss = 1'b0;
		if (ref_valid[0][s] && ref_tag[0][s] == t)
			way = 1'b0;
		else if (ref_valid[1][s] && ref_tag[1][s] == t)
			way = 1'b1;
		else begin
			miss = 1'b1;
			if (!ref_valid[0][s])
				way = 1'b0;
			else if (!ref_valid[1][s])
				way = 1'b1;
			else
				way = ref_lru[s];
			ref_tag[way][s]   = t;
			ref_valid[way][s] = 1'b1;
		end
		ref_lru[s] = ~way; // replayed lookup touches the new way as well
	endtask

	task automatic finish_fetch(input fetch_s f);
		int bad;
		bad = 0;
		if (cpu_data_read !== expected_word(f.addr)) begin
			$display("ERR test %0d cpu_data_read exp %h got %h", f.test,
				expected_word(f.addr), cpu_data_read);
			bad++;
		end
		if (f.miss_seen != f.miss) begin
			$display("test %0d: %s", f.test, f.miss ?
				"expected a line refill but none was requested" : "a hit requested a refill");
			bad++;
		end
		if (!f.delayed && !f.miss && cycle - f.issued != 2) begin
			$display("test %0d: hit returned %0d cycles after issue instead of 2", f.test,
				cycle - f.issued);
			bad++;
		end
		$display("test %0d addr %h %s %s", f.test, f.addr, f.miss ? "miss" : "hit ",
			bad != 0 ? "FAIL" : "ok");
		errors += bad;
		tests++;
	endtask

	// one clock, then look at the outputs
	task automatic tick();
		fetch_s f;
		@(posedge clk);
		#1;
		cycle++;
		if (cpu_ready) begin
			if (pending.size() == 0) begin
				$display("cpu_ready pulsed with no fetch outstanding");
				errors++;
			end else begin
				f = pending.pop_front();
				finish_fetch(f);
			end
		end
		if (mem_req_valid && !last_mem_req) begin
			if (pending.size() == 0) begin
				$display("memory request with no fetch outstanding");
				errors++;
			end else begin
				if (mem_req_addr !== line_of(pending[0].addr)) begin
					$display("ERR test %0d mem_req_addr exp %h got %h", pending[0].test,
						line_of(pending[0].addr), mem_req_addr);
					errors++;
				end
				for (int i = 0; i < pending.size(); i++) begin
					f         = pending[i];
					f.delayed = 1'b1;
					if (i == 0)
						f.miss_seen = 1'b1;
					pending[i] = f;
				end
			end
		end
		last_mem_req = mem_req_valid;
	endtask

	task automatic wait_step(inout int waited, input string what);
		tick();
		waited++;
		if (waited > LIMIT) begin
			$display("timeout while waiting for %s", what);
			$display("CHECKS FAILED");
			$finish;
		end
	endtask

	task automatic apply_row(input int r);
		fetch_s f;
		logic   predicted;
		int     waited;
		waited = 0;
		while (rows[r].gap && (pending.size() != 0 || cpu_busy))
			wait_step(waited, "the cache to go idle");
		waited = 0;
		while (cpu_busy)
			wait_step(waited, "cpu_busy to drop");
		predict(rows[r].addr, predicted);
		if (predicted != rows[r].expect_miss) begin
			$display("table row %0d disagrees with the reference cache", r);
			errors++;
		end
		f = '{next_test, rows[r].addr, predicted, 1'b0, 1'b0, cycle + 1};
		pending.push_back(f);
		next_test++;
		cpu_req_valid = 1'b1;
		cpu_req_addr  = rows[r].addr;
		tick();
		cpu_req_valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (pending.size() != 0 || cpu_busy)
			wait_step(waited, "outstanding fetches to return");
	endtask

	task automatic reset_dut();
		rst_n = 1'b0;
		repeat (2) tick();
		rst_n = 1'b1;
		clear_ref();
	endtask

	initial begin
		rst_n         = 1'b0;
		cpu_req_valid = 1'b0;
		cpu_req_addr  = '0;
		last_mem_req  = 1'b0;
		cycle         = 0;
		tests         = 0;
		errors        = 0;
		next_test     = 0;
		load_table();
		reset_dut();
		for (int r = 0; r < NUM_ROWS; r++)
			apply_row(r);
		drain();
		reset_dut(); // lines filled before must miss again
		for (int r = 0; r < RERUN; r++)
			apply_row(r);
		drain();
		errors += dut0.chk0.fail_cnt;
		$display("%0d tests, %0d issued, %0d errors", tests, next_test, errors);
		if (errors == 0 && tests == next_test)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- compile.f
logic/icache_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_lookup_stage.sv
logic/icache_hit_stage.sv
logic/icache_refill.sv
logic/icache_top.sv
dv/icache_mem_model.sv
dv/icache_checker.sv
dv/icache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       = icache_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
RUN_ARGS  = +verilator+error+limit+1000
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
